/* tb.f */
+incdir+design
design/soc_pkg.sv
design/pi1_router.sv
design/dev_table.sv
design/rst_seq.sv
design/gpio_port.sv
design/soc_top.sv
bench/soc_chk.sv
bench/tb_soc.sv

/* Makefile */
TOP = tb_soc

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o V$(TOP)
	obj_dir/V$(TOP) | awk '{ print } /=== PASS ===/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* bench/tb_soc.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module tb_soc;

	localparam int N_DT = 16;
	localparam int N_GPW = 20;
	localparam int N_IRQ = 8;
	localparam int N_INV = 10;
	localparam int XFER_COUNT = N_DT + 2 * N_GPW + 2 * N_IRQ + 4 * N_INV + 2 * 6 + 2;
	localparam int WD_CYCLES = XFER_COUNT * 4 + 6 * 80 + 500;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	// Word bases of the regions in address order from 0
	localparam logic [29:0] GP0_BASE = 30'(`SOC_MAPSZ_DEVTBL / 4);
	localparam logic [29:0] GP1_BASE = GP0_BASE + 30'(`SOC_MAPSZ_GP0IO / 4);
	localparam logic [29:0] INV_BASE = GP1_BASE + 30'(`SOC_MAPSZ_GP1IO / 4);

	localparam logic [31:0] MODEL_ID [4] = '{`SOC_ID_DEVTBL, `SOC_ID_GPIO, `SOC_ID_GPIO,
		`SOC_ID_INVALID};
	localparam logic [31:0] MODEL_MAPSZ [4] = '{`SOC_MAPSZ_DEVTBL, `SOC_MAPSZ_GP0IO,
		`SOC_MAPSZ_GP1IO, `SOC_MAPSZ_INVALID};

	logic clk_2x_w = 1'b0;
	logic rst_p;
	soc_pkg::pi1_op_e pi1_op_i;
	logic [`SOC_ADDRBITSZ-1:0] pi1_addr_i;
	logic [`SOC_ARCHBITSZ-1:0] pi1_data_i;
	logic [`SOC_SELBITSZ-1:0] pi1_sel_i;
	logic [`SOC_ARCHBITSZ-1:0] pi1_data_o;
	logic pi1_rdy_o;
	logic [`SOC_GP0IOCOUNT-1:0] gp0_i;
	logic [`SOC_GP0IOCOUNT-1:0] gp0_o;
	logic [`SOC_GP1IOCOUNT-1:0] gp1_i;
	logic [1:0] intrqst_o;
	logic sys_rst_o;

	logic [31:0] lfsr_r = 32'hc713;
	logic [31:0] gp_out [2];
	logic [31:0] gp_snap [2];
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	soc_top dut_i (
		.clk_2x_w(clk_2x_w), .rst_p(rst_p),
		.pi1_op_i(pi1_op_i), .pi1_addr_i(pi1_addr_i), .pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i), .pi1_data_o(pi1_data_o), .pi1_rdy_o(pi1_rdy_o),
		.gp0_i(gp0_i), .gp0_o(gp0_o), .gp1_i(gp1_i),
		.intrqst_o(intrqst_o), .sys_rst_o(sys_rst_o)
	);

	always #10 clk_2x_w = ~clk_2x_w;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_r[0]};
			lfsr_r = lfsr_r[0] ? ((lfsr_r >> 1) ^ LFSR_TAPS) : (lfsr_r >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] io_mask(input int bank);
		return (bank == 0) ? 32'((1 << `SOC_GP0IOCOUNT) - 1) :
			32'((1 << `SOC_GP1IOCOUNT) - 1);
	endfunction

	// Expected table word with the control word idle
	function automatic logic [31:0] dt_expect(input int word);
		int k;
		k = (word - `SOC_DT_ENTRY_BASE) / 2;
		if (word == `SOC_DT_REG_SOCID)
			return `SOC_SOCID;
		if (word == `SOC_DT_REG_COUNT)
			return `SOC_SLAVECOUNT;
		if (word >= `SOC_DT_ENTRY_BASE && k < `SOC_SLAVECOUNT) begin
			if ((word - `SOC_DT_ENTRY_BASE) % 2 == 0)
				return MODEL_ID[k];
			return MODEL_MAPSZ[k] | ((k == 1 || k == 2) ? 32'd1 : 32'd0);
		end
		return 32'd0;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("%s", msg);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int start_err);
		if (errors == start_err) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", name, errors - start_err);
			tests_failed++;
		end
	endtask

	task automatic bus_xfer(input soc_pkg::pi1_op_e op, input logic [29:0] addr,
			input logic [31:0] data, input logic [3:0] sel, output logic [31:0] rdata);
		int n;
		n = 0;
		@(posedge clk_2x_w);
		pi1_op_i <= op;
		pi1_addr_i <= addr;
		pi1_data_i <= data;
		pi1_sel_i <= sel;
		do begin
			@(negedge clk_2x_w);
			n++;
		end while (!pi1_rdy_o && n < 8);
		check_true(pi1_rdy_o, $sformatf("no bus ready for word address %h", addr));
		rdata = pi1_data_o;
		@(posedge clk_2x_w);
		pi1_op_i <= soc_pkg::PI1_NOP;
	endtask

	task automatic wait_sys_rst(input logic level, input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk_2x_w);
			cycles++;
		end while (sys_rst_o !== level && cycles < limit);
	endtask

	// After any system reset the outputs clear and the snapshots follow the pins
	task automatic model_reset();
		gp_out[0] = '0;
		gp_out[1] = '0;
		gp_snap[0] = 32'(gp0_i);
		gp_snap[1] = 32'(gp1_i);
	endtask

	task automatic check_regs();
		logic [31:0] rd;
		bus_xfer(soc_pkg::PI1_RD, GP0_BASE + 30'(`SOC_GPIO_REG_OUT), '0, 4'hf, rd);
		check_eq("gp0 out", rd, gp_out[0]);
		bus_xfer(soc_pkg::PI1_RD, GP1_BASE + 30'(`SOC_GPIO_REG_OUT), '0, 4'hf, rd);
		check_eq("gp1 out", rd, gp_out[1]);
		bus_xfer(soc_pkg::PI1_RD, 30'(`SOC_DT_REG_RST), '0, 4'hf, rd);
		check_eq("rst ctl", rd, 32'd0);
	endtask

	task automatic test_devtbl();
		int start;
		int words [N_DT];
		int j;
		int t;
		logic [31:0] rd;
		start = errors;
		for (int i = 0; i < N_DT; i++)
			words[i] = i;
		for (int i = N_DT - 1; i > 0; i--) begin
			j = int'(rand_bits(8)) % (i + 1);
			t = words[i];
			words[i] = words[j];
			words[j] = t;
		end
		foreach (words[i]) begin
			bus_xfer(soc_pkg::PI1_RD, 30'(words[i]), '0, 4'hf, rd);
			check_eq($sformatf("devtbl word %0d", words[i]), rd, dt_expect(words[i]));
		end
		finish_test("device table", start);
	endtask

	task automatic test_gpio_out();
		int start;
		int bank;
		soc_pkg::pi1_op_e op;
		logic [31:0] wdata;
		logic [31:0] mask;
		logic [31:0] old;
		logic [3:0] sel;
		logic [29:0] addr;
		logic [31:0] rd;
		start = errors;
		for (int i = 0; i < N_GPW; i++) begin
			bank = int'(rand_bits(1));
			wdata = rand_bits(32);
			sel = 4'(rand_bits(4));
			op = rand_bits(1) ? soc_pkg::PI1_RDWR : soc_pkg::PI1_WR;
			addr = (bank == 0 ? GP0_BASE : GP1_BASE) + 30'(`SOC_GPIO_REG_OUT);
			for (int b = 0; b < 4; b++)
				mask[b*8 +: 8] = {8{sel[b]}};
			old = gp_out[bank];
			gp_out[bank] = ((old & ~mask) | (wdata & mask)) & io_mask(bank);
			bus_xfer(op, addr, wdata, sel, rd);
			check_eq("pi1_data_o", rd, op == soc_pkg::PI1_RDWR ? old : 32'd0);
			bus_xfer(soc_pkg::PI1_RD, addr, '0, 4'hf, rd);
			check_eq($sformatf("gp%0d out", bank), rd, gp_out[bank]);
			@(negedge clk_2x_w);
			check_eq("gp0_o", 32'(gp0_o), gp_out[0]);
		end
		finish_test("gpio outputs", start);
	endtask

	task automatic test_gpio_irq();
		int start;
		logic [31:0] rd;
		start = errors;
		for (int i = 0; i < N_IRQ; i++) begin
			@(posedge clk_2x_w);
			gp0_i <= 16'(rand_bits(16));
			gp1_i <= 5'(rand_bits(5));
			repeat (4) @(posedge clk_2x_w);
			@(negedge clk_2x_w);
			check_eq("intrqst_o", 32'(intrqst_o),
				{30'd0, 32'(gp1_i) != gp_snap[1], 32'(gp0_i) != gp_snap[0]});
			bus_xfer(soc_pkg::PI1_RD, GP0_BASE + 30'(`SOC_GPIO_REG_IN), '0, 4'hf, rd);
			check_eq("gp0 in", rd, 32'(gp0_i));
			gp_snap[0] = 32'(gp0_i);
			bus_xfer(soc_pkg::PI1_RD, GP1_BASE + 30'(`SOC_GPIO_REG_IN), '0, 4'hf, rd);
			check_eq("gp1 in", rd, 32'(gp1_i));
			gp_snap[1] = 32'(gp1_i);
			repeat (2) @(posedge clk_2x_w);
			@(negedge clk_2x_w);
			check_eq("intrqst_o", 32'(intrqst_o), 32'd0);
		end
		finish_test("gpio interrupts", start);
	endtask

	task automatic test_invalid();
		int start;
		soc_pkg::pi1_op_e op;
		logic [31:0] rd;
		start = errors;
		for (int i = 0; i < N_INV; i++) begin
			op = soc_pkg::pi1_op_e'(2'(rand_bits(2)));
			if (op == soc_pkg::PI1_NOP)
				op = soc_pkg::PI1_RD;
			bus_xfer(op, INV_BASE + 30'(rand_bits(28)), rand_bits(32), 4'hf, rd);
			check_eq("pi1_data_o", rd, 32'd0);
			check_regs();
		end
		finish_test("invalid device", start);
	endtask

	task automatic test_sw_reset();
		int start;
		int n;
		soc_pkg::sw_rst_e code;
		logic [31:0] rd;
		start = errors;
		for (int c = 0; c < 2; c++) begin
			code = (c == 0) ? soc_pkg::SWRST_WARM : soc_pkg::SWRST_COLD;
			bus_xfer(soc_pkg::PI1_WR, GP0_BASE + 30'(`SOC_GPIO_REG_OUT), 32'hffff, 4'hf, rd);
			bus_xfer(soc_pkg::PI1_WR, GP1_BASE + 30'(`SOC_GPIO_REG_OUT), 32'h1f, 4'hf, rd);
			bus_xfer(soc_pkg::PI1_WR, 30'(`SOC_DT_REG_RST), 32'(code), 4'b0001, rd);
			wait_sys_rst(1'b1, 4, n);
			check_true(sys_rst_o, "sys_rst_o did not rise after a reset request");
			wait_sys_rst(1'b0, 70, n);
			check_true(!sys_rst_o, "sys_rst_o stayed high longer than 70 cycles");
			model_reset();
			check_eq("gp0_o", 32'(gp0_o), 32'd0);
			check_regs();
		end
		finish_test("warm and cold reset", start);
	endtask

	task automatic test_pwroff();
		int start;
		int n;
		logic held_ok;
		logic [31:0] rd;
		start = errors;
		bus_xfer(soc_pkg::PI1_WR, 30'(`SOC_DT_REG_RST), 32'(soc_pkg::SWRST_PWROFF),
			4'b0001, rd);
		wait_sys_rst(1'b1, 4, n);
		check_true(sys_rst_o, "sys_rst_o did not rise after the power-off request");
		// A held read must not complete while powered off
		held_ok = 1'b1;
		@(posedge clk_2x_w);
		pi1_op_i <= soc_pkg::PI1_RD;
		pi1_addr_i <= 30'(`SOC_DT_REG_SOCID);
		repeat (200) begin
			@(negedge clk_2x_w);
			if (!sys_rst_o || pi1_rdy_o)
				held_ok = 1'b0;
		end
		check_true(held_ok, "bus completed or sys_rst_o fell during power-off");
		@(posedge clk_2x_w);
		pi1_op_i <= soc_pkg::PI1_NOP;
		rst_p <= 1'b1;
		repeat (16) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		wait_sys_rst(1'b0, 80, n);
		check_true(!sys_rst_o, "sys_rst_o stayed high after the pin reset");
		model_reset();
		bus_xfer(soc_pkg::PI1_RD, 30'(`SOC_DT_REG_SOCID), '0, 4'hf, rd);
		check_eq("pi1_data_o", rd, `SOC_SOCID);
		finish_test("power-off", start);
	endtask

	initial begin
		repeat (WD_CYCLES) @(posedge clk_2x_w);
		$display("watchdog expired after %0d cycles", WD_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int n;
		rst_p = 1'b1;
		pi1_op_i = soc_pkg::PI1_NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i = '0;
		gp0_i = '0;
		gp1_i = '0;
		repeat (16) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		wait_sys_rst(1'b0, 80, n);
		check_true(!sys_rst_o, "system reset did not release after the pin reset");
		model_reset();
		test_devtbl();
		test_gpio_out();
		test_gpio_irq();
		test_invalid();
		test_sw_reset();
		test_pwroff();
		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/soc_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_chk (
	input logic             clk_2x_w,
	input logic             sys_rst_i,
	input logic             rdy_i,
	input soc_pkg::pi1_op_e dt_op_i,
	input soc_pkg::pi1_op_e gp0_op_i,
	input soc_pkg::pi1_op_e gp1_op_i
);

	// Ready stays low while the system is held in reset
	rdy_in_reset: assert property (@(posedge clk_2x_w) disable iff ($isunknown(rdy_i))
		!(sys_rst_i && rdy_i))
		else $error("bus ready high during system reset");

	rdy_single: assert property (@(posedge clk_2x_w) rdy_i |=> !rdy_i)
		else $error("bus ready high for two cycles in a row");

	// Only one slave sees a live op
	one_slave_op: assert property (@(posedge clk_2x_w)
		$onehot0({dt_op_i != soc_pkg::PI1_NOP, gp0_op_i != soc_pkg::PI1_NOP,
			gp1_op_i != soc_pkg::PI1_NOP}))
		else $error("more than one slave op active in the same cycle");

endmodule

bind pi1_router soc_chk u_chk (
	.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst_i), .rdy_i(pi1_rdy_o),
	.dt_op_i(dt_op_o), .gp0_op_i(gp0_op_o), .gp1_op_i(gp1_op_o)
);

`default_nettype wire

/* design/soc_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module soc_top (
	input  logic                          clk_2x_w,
	input  logic                          rst_p,
	input  soc_pkg::pi1_op_e              pi1_op_i,
	input  logic [`SOC_ADDRBITSZ-1:0]     pi1_addr_i,
	input  logic [`SOC_ARCHBITSZ-1:0]     pi1_data_i,
	input  logic [`SOC_SELBITSZ-1:0]      pi1_sel_i,
	output logic [`SOC_ARCHBITSZ-1:0]     pi1_data_o,
	output logic                          pi1_rdy_o,
	input  logic [`SOC_GP0IOCOUNT-1:0]    gp0_i,
	output logic [`SOC_GP0IOCOUNT-1:0]    gp0_o,
	input  logic [`SOC_GP1IOCOUNT-1:0]    gp1_i,
	output logic [1:0]                    intrqst_o,
	output logic                          sys_rst_o
);

	logic                         sys_rst;
	soc_pkg::sw_rst_e             sw_rst;
	soc_pkg::pi1_op_e             dt_op;
	soc_pkg::pi1_op_e             gp0_op;
	soc_pkg::pi1_op_e             gp1_op;
	logic [`SOC_OFFBITSZ-1:0]     slv_addr;
	logic [`SOC_ARCHBITSZ-1:0]    slv_data;
	logic [`SOC_SELBITSZ-1:0]     slv_sel;
	logic [`SOC_ARCHBITSZ-1:0]    dt_rdata;
	logic [`SOC_ARCHBITSZ-1:0]    gp0_rdata;
	logic [`SOC_ARCHBITSZ-1:0]    gp1_rdata;

	pi1_router u_router (
		.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst),
		.pi1_op_i(pi1_op_i), .pi1_addr_i(pi1_addr_i), .pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i), .pi1_data_o(pi1_data_o), .pi1_rdy_o(pi1_rdy_o),
		.dt_rdata_i(dt_rdata), .gp0_rdata_i(gp0_rdata), .gp1_rdata_i(gp1_rdata),
		.dt_op_o(dt_op), .gp0_op_o(gp0_op), .gp1_op_o(gp1_op),
		.slv_addr_o(slv_addr), .slv_data_o(slv_data), .slv_sel_o(slv_sel)
	);

	dev_table u_devtbl (
		.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst),
		.op_i(dt_op), .addr_i(slv_addr), .data_i(slv_data), .sel_i(slv_sel),
		.rdata_o(dt_rdata), .sw_rst_o(sw_rst)
	);

	rst_seq u_rstseq (
		.clk_2x_w(clk_2x_w), .rst_p(rst_p), .sw_rst_i(sw_rst), .sys_rst_o(sys_rst)
	);

	gpio_port #(.IOCOUNT(`SOC_GP0IOCOUNT)) u_gpio0 (
		.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst),
		.op_i(gp0_op), .addr_i(slv_addr), .data_i(slv_data), .sel_i(slv_sel),
		.io_i(gp0_i), .rdata_o(gp0_rdata), .io_o(gp0_o), .intrqst_o(intrqst_o[0])
	);

	// Button bank has no outputs on the board
	gpio_port #(.IOCOUNT(`SOC_GP1IOCOUNT)) u_gpio1 (
		.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst),
		.op_i(gp1_op), .addr_i(slv_addr), .data_i(slv_data), .sel_i(slv_sel),
		.io_i(gp1_i), .rdata_o(gp1_rdata), .io_o(), .intrqst_o(intrqst_o[1])
	);

	assign sys_rst_o = sys_rst;

endmodule

`default_nettype wire

/* design/gpio_port.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module gpio_port #(
	parameter int IOCOUNT = `SOC_GP0IOCOUNT
) (
	input  logic                        clk_2x_w,
	input  logic                        sys_rst_i,
	input  soc_pkg::pi1_op_e            op_i,
	input  logic [`SOC_OFFBITSZ-1:0]    addr_i,
	input  logic [`SOC_ARCHBITSZ-1:0]   data_i,
	input  logic [`SOC_SELBITSZ-1:0]    sel_i,
	input  logic [IOCOUNT-1:0]          io_i,
	output logic [`SOC_ARCHBITSZ-1:0]   rdata_o,
	output logic [IOCOUNT-1:0]          io_o,
	output logic                        intrqst_o
);

	logic [IOCOUNT-1:0]          meta_r;
	logic [IOCOUNT-1:0]          sync_r;
	logic [IOCOUNT-1:0]          snap_r;
	logic [IOCOUNT-1:0]          out_r;
	logic [`SOC_ARCHBITSZ-1:0]   sel_mask;
	logic                        rd_op;
	logic                        wr_op;
	logic                        in_rd;
	logic                        out_wr;

	assign rd_op  = (op_i == soc_pkg::PI1_RD || op_i == soc_pkg::PI1_RDWR);
	assign wr_op  = (op_i == soc_pkg::PI1_WR || op_i == soc_pkg::PI1_RDWR);
	assign in_rd  = rd_op && (addr_i == `SOC_GPIO_REG_IN);
	assign out_wr = wr_op && (addr_i == `SOC_GPIO_REG_OUT);

	// Two-flop synchronizer on the pins
	always_ff @(posedge clk_2x_w) begin
		meta_r <= io_i;
		sync_r <= meta_r;
	end

	// Snapshot follows the inputs through reset so no stale change is flagged
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i || in_rd)
			snap_r <= sync_r;
	end

	always_comb begin
		for (int b = 0; b < `SOC_SELBITSZ; b++)
			sel_mask[b*8 +: 8] = {8{sel_i[b]}};
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			out_r <= '0;
		end else if (out_wr) begin
			out_r <= (out_r & ~sel_mask[IOCOUNT-1:0]) |
				(data_i[IOCOUNT-1:0] & sel_mask[IOCOUNT-1:0]);
		end
	end

	// Unused upper bits read as zero
	always_comb begin
		rdata_o = '0;
		if (addr_i == `SOC_GPIO_REG_IN)
			rdata_o[IOCOUNT-1:0] = sync_r;
		else if (addr_i == `SOC_GPIO_REG_OUT)
			rdata_o[IOCOUNT-1:0] = out_r;
	end

	assign io_o      = out_r;
	assign intrqst_o = (sync_r != snap_r);

endmodule

`default_nettype wire

/* design/rst_seq.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module rst_seq (
	input  logic              clk_2x_w,
	input  logic              rst_p,
	input  soc_pkg::sw_rst_e  sw_rst_i,
	output logic              sys_rst_o
);

	logic [`SOC_RST_CNTR_BITSZ-1:0] cntr_r;
	logic                           pwroff_r;
	logic                           reload;
	logic                           pwroff_req;

	// Cold has no global set/reset to act on, so it reloads like warm
	assign reload = rst_p ||
		(sw_rst_i == soc_pkg::SWRST_WARM) ||
		(sw_rst_i == soc_pkg::SWRST_COLD);

	assign pwroff_req = (sw_rst_i == soc_pkg::SWRST_PWROFF);

	always_ff @(posedge clk_2x_w) begin
		if (reload) begin
			cntr_r <= '1;
		end else if (cntr_r != '0) begin
			cntr_r <= cntr_r - 1'b1;
		end
	end

	// Power-off holds the system in reset until the pin reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_r <= 1'b0;
		end else if (pwroff_req) begin
			pwroff_r <= 1'b1;
		end
	end

	assign sys_rst_o = (cntr_r != '0) || pwroff_r;

endmodule

`default_nettype wire

/* design/dev_table.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module dev_table (
	input  logic                        clk_2x_w,
	input  logic                        sys_rst_i,
	input  soc_pkg::pi1_op_e            op_i,
	input  logic [`SOC_OFFBITSZ-1:0]    addr_i,
	input  logic [`SOC_ARCHBITSZ-1:0]   data_i,
	input  logic [`SOC_SELBITSZ-1:0]    sel_i,
	output logic [`SOC_ARCHBITSZ-1:0]   rdata_o,
	output soc_pkg::sw_rst_e            sw_rst_o
);

	localparam int IDXBITSZ = $clog2(`SOC_SLAVECOUNT);

	// Per-slave entries in slave_e order
	localparam logic [`SOC_ARCHBITSZ-1:0] DEV_ID [`SOC_SLAVECOUNT] = '{
		`SOC_ID_DEVTBL,
		`SOC_ID_GPIO,
		`SOC_ID_GPIO,
		`SOC_ID_INVALID
	};
	localparam logic [`SOC_ARCHBITSZ-1:0] DEV_MAPSZ [`SOC_SLAVECOUNT] = '{
		`SOC_MAPSZ_DEVTBL,
		`SOC_MAPSZ_GP0IO,
		`SOC_MAPSZ_GP1IO,
		`SOC_MAPSZ_INVALID
	};
	// Only the two GPIO banks raise interrupts
	localparam logic [`SOC_SLAVECOUNT-1:0] DEV_USEINTR = 4'b0110;

	soc_pkg::sw_rst_e             rst_ctl_r;
	logic [`SOC_OFFBITSZ-1:0]     ent_off;
	logic [IDXBITSZ-1:0]          ent_idx;
	logic                         ent_hit;
	logic                         wr_en;

	assign wr_en = (op_i == soc_pkg::PI1_WR || op_i == soc_pkg::PI1_RDWR);

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i)
			rst_ctl_r <= soc_pkg::SWRST_NONE;
		else if (wr_en && addr_i == `SOC_DT_REG_RST && sel_i[0])
			rst_ctl_r <= soc_pkg::sw_rst_e'(data_i[1:0]);
	end

	// Two words per slave, id then map size
	assign ent_off = addr_i - `SOC_OFFBITSZ'(`SOC_DT_ENTRY_BASE);
	assign ent_hit = (addr_i >= `SOC_DT_ENTRY_BASE) &&
		(ent_off < `SOC_OFFBITSZ'(2 * `SOC_SLAVECOUNT));
	assign ent_idx = ent_off[IDXBITSZ:1];

	always_comb begin
		rdata_o = '0;
		if (addr_i == `SOC_DT_REG_SOCID) begin
			rdata_o = `SOC_SOCID;
		end else if (addr_i == `SOC_DT_REG_COUNT) begin
			rdata_o = `SOC_SLAVECOUNT;
		end else if (addr_i == `SOC_DT_REG_RST) begin
			rdata_o[1:0] = rst_ctl_r;
		end else if (ent_hit) begin
			if (ent_off[0])
				rdata_o = DEV_MAPSZ[ent_idx] | `SOC_ARCHBITSZ'(DEV_USEINTR[ent_idx]);
			else
				rdata_o = DEV_ID[ent_idx];
		end
	end

	assign sw_rst_o = rst_ctl_r;

endmodule

`default_nettype wire

/* design/pi1_router.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module pi1_router (
	input  logic                        clk_2x_w,
	input  logic                        sys_rst_i,
	input  soc_pkg::pi1_op_e            pi1_op_i,
	input  logic [`SOC_ADDRBITSZ-1:0]   pi1_addr_i,
	input  logic [`SOC_ARCHBITSZ-1:0]   pi1_data_i,
	input  logic [`SOC_SELBITSZ-1:0]    pi1_sel_i,
	output logic [`SOC_ARCHBITSZ-1:0]   pi1_data_o,
	output logic                        pi1_rdy_o,
	input  logic [`SOC_ARCHBITSZ-1:0]   dt_rdata_i,
	input  logic [`SOC_ARCHBITSZ-1:0]   gp0_rdata_i,
	input  logic [`SOC_ARCHBITSZ-1:0]   gp1_rdata_i,
	output soc_pkg::pi1_op_e            dt_op_o,
	output soc_pkg::pi1_op_e            gp0_op_o,
	output soc_pkg::pi1_op_e            gp1_op_o,
	output logic [`SOC_OFFBITSZ-1:0]    slv_addr_o,
	output logic [`SOC_ARCHBITSZ-1:0]   slv_data_o,
	output logic [`SOC_SELBITSZ-1:0]    slv_sel_o
);

	localparam int WORDBYTES = `SOC_ARCHBITSZ / 8;

	// Word base of each region, regions follow each other from 0
	localparam logic [`SOC_ADDRBITSZ-1:0] GP0_BASE =
		`SOC_ADDRBITSZ'(`SOC_MAPSZ_DEVTBL / WORDBYTES);
	localparam logic [`SOC_ADDRBITSZ-1:0] GP1_BASE =
		GP0_BASE + `SOC_ADDRBITSZ'(`SOC_MAPSZ_GP0IO / WORDBYTES);
	localparam logic [`SOC_ADDRBITSZ-1:0] INV_BASE =
		GP1_BASE + `SOC_ADDRBITSZ'(`SOC_MAPSZ_GP1IO / WORDBYTES);

	soc_pkg::rtr_state_e              state_r;
	soc_pkg::pi1_op_e                 op_r;
	soc_pkg::slave_e                  slave_r;
	soc_pkg::slave_e                  req_slave;
	logic [`SOC_ADDRBITSZ-1:0]        req_base;
	logic [`SOC_ADDRBITSZ-1:0]        req_off;
	logic [`SOC_OFFBITSZ-1:0]         off_r;
	logic [`SOC_ARCHBITSZ-1:0]        wdata_r;
	logic [`SOC_SELBITSZ-1:0]         sel_r;
	logic [`SOC_ARCHBITSZ-1:0]        slv_rdata;
	logic [`SOC_ARCHBITSZ-1:0]        rdata_r;

	// Anything past the last GPIO bank lands on the invalid device
	always_comb begin
		if (pi1_addr_i < GP0_BASE) begin
			req_slave = soc_pkg::S_DEVTBL;
			req_base  = '0;
		end else if (pi1_addr_i < GP1_BASE) begin
			req_slave = soc_pkg::S_GP0IO;
			req_base  = GP0_BASE;
		end else if (pi1_addr_i < INV_BASE) begin
			req_slave = soc_pkg::S_GP1IO;
			req_base  = GP1_BASE;
		end else begin
			req_slave = soc_pkg::S_INVALID;
			req_base  = INV_BASE;
		end
		req_off = pi1_addr_i - req_base;
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			state_r <= soc_pkg::RTR_IDLE;
		end else begin
			case (state_r)
				soc_pkg::RTR_IDLE:  if (pi1_op_i != soc_pkg::PI1_NOP) state_r <= soc_pkg::RTR_ISSUE;
				soc_pkg::RTR_ISSUE: state_r <= soc_pkg::RTR_RESP;
				default:            state_r <= soc_pkg::RTR_IDLE;
			endcase
		end
	end

	// Request is captured on the edge that leaves idle
	always_ff @(posedge clk_2x_w) begin
		if (state_r == soc_pkg::RTR_IDLE) begin
			op_r    <= pi1_op_i;
			slave_r <= req_slave;
			off_r   <= req_off[`SOC_OFFBITSZ-1:0];
			wdata_r <= pi1_data_i;
			sel_r   <= pi1_sel_i;
		end
		if (state_r == soc_pkg::RTR_ISSUE) begin
			if (op_r == soc_pkg::PI1_WR || slave_r == soc_pkg::S_INVALID)
				rdata_r <= '0;
			else
				rdata_r <= slv_rdata;
		end
	end

	always_comb begin
		case (slave_r)
			soc_pkg::S_DEVTBL: slv_rdata = dt_rdata_i;
			soc_pkg::S_GP0IO:  slv_rdata = gp0_rdata_i;
			soc_pkg::S_GP1IO:  slv_rdata = gp1_rdata_i;
			default:           slv_rdata = '0;
		endcase
	end

	// One slave sees the op for the single issue cycle
	always_comb begin
		dt_op_o  = soc_pkg::PI1_NOP;
		gp0_op_o = soc_pkg::PI1_NOP;
		gp1_op_o = soc_pkg::PI1_NOP;
		if (state_r == soc_pkg::RTR_ISSUE) begin
			case (slave_r)
				soc_pkg::S_DEVTBL: dt_op_o  = op_r;
				soc_pkg::S_GP0IO:  gp0_op_o = op_r;
				soc_pkg::S_GP1IO:  gp1_op_o = op_r;
				default:           ;
			endcase
		end
	end

	assign slv_addr_o = off_r;
	assign slv_data_o = wdata_r;
	assign slv_sel_o  = sel_r;
	assign pi1_data_o = rdata_r;
	assign pi1_rdy_o  = (state_r == soc_pkg::RTR_RESP);

endmodule

`default_nettype wire

/* design/soc_pkg.sv */
`default_nettype none

`include "soc_defines.svh"

package soc_pkg;

	// Bus opcodes, RDWR returns the old value and writes the new one
	typedef enum logic [`SOC_OPBITSZ-1:0] {
		PI1_NOP  = 2'd0,
		PI1_WR   = 2'd1,
		PI1_RD   = 2'd2,
		PI1_RDWR = 2'd3
	} pi1_op_e;

	typedef enum logic [1:0] {
		RTR_IDLE,
		RTR_ISSUE,
		RTR_RESP
	} rtr_state_e;

	// Slaves in address order
	typedef enum logic [1:0] {
		S_DEVTBL  = 2'd0,
		S_GP0IO   = 2'd1,
		S_GP1IO   = 2'd2,
		S_INVALID = 2'd3
	} slave_e;

	// Reset control bits {rst1,rst0}
	typedef enum logic [1:0] {
		SWRST_NONE   = 2'b00,
		SWRST_PWROFF = 2'b01,
		SWRST_WARM   = 2'b10,
		SWRST_COLD   = 2'b11
	} sw_rst_e;

endpackage

`default_nettype wire

/* design/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define SOC_ARCHBITSZ 32
`define SOC_ADDRBITSZ 30
`define SOC_SELBITSZ 4
`define SOC_OPBITSZ 2
// Word offset width inside one 4 KB region
`define SOC_OFFBITSZ 10

// Region sizes in bytes, in address order
`define SOC_MAPSZ_DEVTBL 'h1000
`define SOC_MAPSZ_GP0IO 'h1000
`define SOC_MAPSZ_GP1IO 'h1000
`define SOC_MAPSZ_INVALID 'h1000
`define SOC_SLAVECOUNT 4

// Device ids as reported by the device table
`define SOC_ID_DEVTBL 7
`define SOC_ID_GPIO 6
`define SOC_ID_INVALID 0
`define SOC_SOCID 2

`define SOC_GP0IOCOUNT 16
`define SOC_GP1IOCOUNT 5
`define SOC_RST_CNTR_BITSZ 6

// Register word offsets
`define SOC_DT_REG_SOCID 0
`define SOC_DT_REG_COUNT 1
`define SOC_DT_REG_RST 2
`define SOC_DT_ENTRY_BASE 8
`define SOC_GPIO_REG_IN 0
`define SOC_GPIO_REG_OUT 1

`endif
